/* sim.f */
src/core_pkg.sv
src/alu.sv
src/bypass_buffer.sv
src/regfile.sv
src/exu.sv
src/lsu.sv
src/exec_top.sv
test/clk_gen.sv
test/exec_top_asserts.sv
test/exec_top_tb.sv

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_t op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result,
    output logic              cond
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_slt:    result = {{(XLEN-1){1'b0}}, lt_s};
            alu_sltu:   result = {{(XLEN-1){1'b0}}, lt_u};
            alu_pass_b: result = b;
            default:    result = '0;   // branches produce no data
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch condition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op)
            alu_beq:  cond = eq;
            alu_bne:  cond = !eq;
            alu_blt:  cond = lt_s;
            alu_bge:  cond = !lt_s;
            alu_bltu: cond = lt_u;
            default:  cond = 1'b0;   // never taken for plain arithmetic
        endcase
    end

endmodule

/* src/bypass_buffer.sv */
`timescale 1ns/1ps

module bypass_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  core_pkg::reg_idx_t push_rd,
    input  core_pkg::word_t    push_data,
    input  logic               push_load,
    input  logic               fill,
    input  core_pkg::word_t    fill_data,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output logic               fwd_hit1,
    output logic               fwd_pend1,
    output core_pkg::word_t    fwd_data1,
    output logic               fwd_hit2,
    output logic               fwd_pend2,
    output core_pkg::word_t    fwd_data2
);
    import core_pkg::*;

    logic [BYPASS_DEPTH-1:0] ent_valid;
    logic [BYPASS_DEPTH-1:0] ent_pend;
    reg_idx_t                ent_rd   [BYPASS_DEPTH];
    word_t                   ent_data [BYPASS_DEPTH];

    logic [BYPASS_DEPTH-1:0] fill_sel;
    logic                    fill_found;

    // slot 0 is the youngest, so the oldest pending load sits at the highest index
    always_comb begin
        fill_sel   = '0;
        fill_found = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (!fill_found && ent_valid[i] && ent_pend[i]) begin
                fill_sel[i] = fill;
                fill_found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            ent_pend  <= '0;
        end else if (push) begin
            ent_valid <= {ent_valid[BYPASS_DEPTH-2:0], 1'b1};
            ent_pend  <= {ent_pend[BYPASS_DEPTH-2:0] & ~fill_sel[BYPASS_DEPTH-2:0], push_load};
        end else begin
            ent_pend  <= ent_pend & ~fill_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ent_rd[0]   <= push_rd;
            ent_data[0] <= push_data;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                ent_rd[i]   <= ent_rd[i-1];
                ent_data[i] <= fill_sel[i-1] ? fill_data : ent_data[i-1];   // fill lands before the shift
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                if (fill_sel[i]) begin
                    ent_data[i] <= fill_data;
                end
            end
        end
    end

    // walk from oldest to youngest so the youngest match is the one left standing
    function automatic logic [XLEN+1:0] lookup(input reg_idx_t rs);
        logic [XLEN+1:0] hit_pend_data;
        hit_pend_data = '0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent_rd[i] == rs && rs != '0) begin
                hit_pend_data = {1'b1, ent_pend[i], ent_data[i]};
            end
        end
        return hit_pend_data;
    endfunction

    always_comb begin
        {fwd_hit1, fwd_pend1, fwd_data1} = lookup(rs1);
        {fwd_hit2, fwd_pend2, fwd_data2} = lookup(rs2);
    end

endmodule

/* src/core_pkg.sv */
package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;

    localparam int BYPASS_DEPTH = 4;   // any value of 2 or more keeps forwarding correct

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;   // word index, taken from address bits 7:2

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b,   // lui puts the immediate on b
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu
    } alu_op_t;

    // Branch operations only drive cond, the result is zero for them

endpackage

/* src/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  core_pkg::word_t    issue_pc,
    input  core_pkg::alu_op_t  issue_op,
    input  core_pkg::reg_idx_t issue_rd,
    input  core_pkg::reg_idx_t issue_rs1,
    input  core_pkg::reg_idx_t issue_rs2,
    input  core_pkg::word_t    issue_imm,
    input  logic               issue_use_imm,
    input  logic               issue_use_pc,
    input  logic               issue_wen,
    input  logic               issue_load,
    input  logic               issue_store,
    input  logic               issue_jump,
    input  logic               issue_branch,
    output logic               redirect_valid,
    output core_pkg::word_t    redirect_pc,
    input  logic               redirect_ack,
    output logic               wb_valid,
    output logic               wb_wen,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t    wb_data
);
    import core_pkg::*;

    reg_idx_t rf_raddr1, rf_raddr2, push_rd, ex_rd;
    word_t    rf_rdata1, rf_rdata2, fwd_data1, fwd_data2, push_data, ex_result, ex_store_data;
    logic     fwd_hit1, fwd_pend1, fwd_hit2, fwd_pend2, push, push_load;
    logic     ex_valid, ex_wen, ex_load, ex_store, wb_load;

    exu exu_inst (
        .clk, .rst,
        .issue_valid, .issue_ready, .issue_pc, .issue_op, .issue_rd, .issue_rs1, .issue_rs2,
        .issue_imm, .issue_use_imm, .issue_use_pc, .issue_wen, .issue_load, .issue_store,
        .issue_jump, .issue_branch,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .fwd_hit1, .fwd_pend1, .fwd_data1, .fwd_hit2, .fwd_pend2, .fwd_data2,
        .push, .push_rd, .push_data, .push_load,
        .ex_valid, .ex_rd, .ex_wen, .ex_load, .ex_store, .ex_result, .ex_store_data,
        .redirect_valid, .redirect_pc, .redirect_ack
    );

    bypass_buffer bypass_buffer_inst (
        .clk, .rst,
        .push, .push_rd, .push_data, .push_load,
        .fill      (wb_valid && wb_load),
        .fill_data (wb_data),
        .rs1       (rf_raddr1),
        .rs2       (rf_raddr2),
        .fwd_hit1, .fwd_pend1, .fwd_data1, .fwd_hit2, .fwd_pend2, .fwd_data2
    );

    regfile regfile_inst (
        .clk, .rst,
        .raddr1 (rf_raddr1), .raddr2 (rf_raddr2), .rdata1 (rf_rdata1), .rdata2 (rf_rdata2),
        .we     (wb_valid && wb_wen), .waddr (wb_rd), .wdata (wb_data)
    );

    lsu lsu_inst (
        .clk, .rst,
        .ex_valid, .ex_rd, .ex_wen, .ex_load, .ex_store, .ex_result, .ex_store_data,
        .wb_valid, .wb_wen, .wb_rd, .wb_data, .wb_load
    );

endmodule

/* src/exu.sv */
`timescale 1ns/1ps

module exu (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  core_pkg::word_t    issue_pc,
    input  core_pkg::alu_op_t  issue_op,
    input  core_pkg::reg_idx_t issue_rd,
    input  core_pkg::reg_idx_t issue_rs1,
    input  core_pkg::reg_idx_t issue_rs2,
    input  core_pkg::word_t    issue_imm,
    input  logic               issue_use_imm,
    input  logic               issue_use_pc,
    input  logic               issue_wen,
    input  logic               issue_load,
    input  logic               issue_store,
    input  logic               issue_jump,
    input  logic               issue_branch,
    output core_pkg::reg_idx_t rf_raddr1,
    output core_pkg::reg_idx_t rf_raddr2,
    input  core_pkg::word_t    rf_rdata1,
    input  core_pkg::word_t    rf_rdata2,
    input  logic               fwd_hit1,
    input  logic               fwd_pend1,
    input  core_pkg::word_t    fwd_data1,
    input  logic               fwd_hit2,
    input  logic               fwd_pend2,
    input  core_pkg::word_t    fwd_data2,
    output logic               push,
    output core_pkg::reg_idx_t push_rd,
    output core_pkg::word_t    push_data,
    output logic               push_load,
    output logic               ex_valid,
    output core_pkg::reg_idx_t ex_rd,
    output logic               ex_wen,
    output logic               ex_load,
    output logic               ex_store,
    output core_pkg::word_t    ex_result,
    output core_pkg::word_t    ex_store_data,
    output logic               redirect_valid,
    output core_pkg::word_t    redirect_pc,
    input  logic               redirect_ack
);
    import core_pkg::*;

    word_t src1, src2, alu_a, alu_b, alu_out, mem_addr, result, target;
    logic  cond, use_rs1, use_rs2, taken, accept, live;

    // rs indices also go to the bypass buffer lookup
    assign rf_raddr1 = issue_rs1;
    assign rf_raddr2 = issue_rs2;

    assign src1  = fwd_hit1 ? fwd_data1 : rf_rdata1;
    assign src2  = fwd_hit2 ? fwd_data2 : rf_rdata2;
    assign alu_a = issue_use_pc  ? issue_pc  : src1;
    assign alu_b = issue_use_imm ? issue_imm : src2;

    // only a source that is actually read can hold up issue
    assign use_rs1     = !issue_use_pc || issue_load || issue_store;
    assign use_rs2     = !issue_use_imm || issue_store;
    assign issue_ready = !((use_rs1 && fwd_pend1) || (use_rs2 && fwd_pend2));

    assign accept = issue_valid && issue_ready;
    assign live   = accept && !redirect_valid;   // wrong-path ops are dropped here

    alu alu_inst (
        .op     (issue_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_out),
        .cond   (cond)
    );

    assign mem_addr = src1 + issue_imm;
    assign result   = issue_jump                 ? issue_pc + 32'd4 :
                      (issue_load || issue_store) ? mem_addr         : alu_out;
    assign taken    = issue_jump || (issue_branch && cond);
    assign target   = issue_jump ? {alu_out[XLEN-1:1], 1'b0} : issue_pc + issue_imm;

    assign push      = live && issue_wen;
    assign push_rd   = issue_rd;
    assign push_data = result;   // for a load this is the address until the fill
    assign push_load = issue_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            ex_valid       <= 1'b0;
        end else begin
            if (redirect_valid && redirect_ack) begin
                redirect_valid <= 1'b0;
            end else if (live && taken) begin
                redirect_valid <= 1'b1;
            end
            ex_valid <= live;
        end
    end

    always_ff @(posedge clk) begin
        if (live && taken) begin
            redirect_pc <= target;
        end
        if (live) begin
            ex_rd         <= issue_rd;
            ex_wen        <= issue_wen;
            ex_load       <= issue_load;
            ex_store      <= issue_store;
            ex_result     <= result;
            ex_store_data <= src2;
        end
    end

endmodule

/* src/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    input  core_pkg::reg_idx_t ex_rd,
    input  logic               ex_wen,
    input  logic               ex_load,
    input  logic               ex_store,
    input  core_pkg::word_t    ex_result,
    input  core_pkg::word_t    ex_store_data,
    output logic               wb_valid,
    output logic               wb_wen,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t    wb_data,
    output logic               wb_load
);
    import core_pkg::*;

    word_t     dmem [DMEM_WORDS];
    dmem_idx_t idx;
    word_t     rd_word;

    assign idx     = ex_result[DMEM_IDX_W+1:2];   // word aligned, low bits ignored
    assign rd_word = dmem[idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_valid && ex_store) begin
            dmem[idx] <= ex_store_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_wen  <= ex_wen;
            wb_rd   <= ex_rd;
            wb_data <= ex_load ? rd_word : ex_result;
            wb_load <= ex_load && ex_wen;   // a load without wen left no bypass entry to fill
        end
    end

endmodule

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2,
    input  logic               we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata
);
    import core_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != '0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* test/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* test/exec_top_asserts.sv */
`timescale 1ns/1ps

module exec_top_asserts (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input logic issue_ready,
    input logic ex_valid,
    input logic redirect_valid,
    input logic redirect_ack
);
    int unsigned fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // redirect protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    redirect_held: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid)
        else begin
            $error("redirect_valid dropped before it was acknowledged");
            fail_count++;
        end

    wrong_path_dropped: assert property (@(posedge clk) disable iff (rst)
        issue_valid && issue_ready && redirect_valid |=> !ex_valid)
        else begin
            $error("ex_valid raised for an op accepted during a redirect");
            fail_count++;
        end

    // every edge with rst high leaves the valids cleared
    quiet_in_reset: assert property (@(posedge clk) rst |=> !ex_valid && !redirect_valid)
        else begin
            $error("a valid is high while the block is held in reset");
            fail_count++;
        end

endmodule

/* test/exec_top_tb.sv */
`timescale 1ns/1ps

module exec_top_tb;
    import core_pkg::*;

    localparam int k_rr = 0, k_ri = 1, k_ld = 2, k_st = 3, k_br = 4, k_jal = 5;
    localparam int k_wp = 6, k_wp_ack = 7;   // wrong-path rows and the one that also acknowledges
    localparam int max_wait = 20;

    typedef struct packed {
        word_t    pc;
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;
        logic     use_pc;
        logic     wen;
        logic     load;
        logic     store;
        logic     jump;
        logic     branch;
        logic     ack;
        logic     stall;
        logic     expect_wb;
        word_t    wb_data;
        logic     redirect;
        word_t    target;
    } op_row_t;

    logic     clk, rst, issue_valid, issue_ready, issue_use_imm, issue_use_pc, issue_wen;
    logic     issue_load, issue_store, issue_jump, issue_branch;
    logic     redirect_valid, redirect_ack, wb_valid, wb_wen;
    word_t    issue_pc, issue_imm, redirect_pc, wb_data;
    alu_op_t  issue_op;
    reg_idx_t issue_rd, issue_rs1, issue_rs2, wb_rd;

    op_row_t  rows [$];
    reg_idx_t exp_rd_q [$];
    word_t    exp_data_q [$];
    word_t    model_regs [32];
    word_t    model_mem [DMEM_WORDS];
    word_t    next_pc, exp_target, exp_data, rnd;
    reg_idx_t exp_rd;
    logic     exp_redirect, stall_next, aborted;
    int       mismatch_errs, timeout_errs, other_errs, total;

    clk_gen clk_gen_inst (.clk(clk), .rst(rst));

    exec_top exec_top_inst (.*);

    bind exu exec_top_asserts asserts_inst (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .ex_valid(ex_valid), .redirect_valid(redirect_valid), .redirect_ack(redirect_ack)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // golden model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_and:    return a & b;
            alu_or:     return a | b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << b[4:0];
            alu_srl:    return a >> b[4:0];
            alu_sra:    return $signed(a) >>> b[4:0];
            alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
            alu_pass_b: return b;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic ref_cond(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_beq:  return a == b;
            alu_bne:  return a != b;
            alu_blt:  return $signed(a) < $signed(b);
            alu_bge:  return $signed(a) >= $signed(b);
            alu_bltu: return a < b;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // runs the op on the model in program order and appends it with its expectations
    task automatic add_row(int kind, alu_op_t op, reg_idx_t rd, reg_idx_t rs1,
                           reg_idx_t rs2, word_t imm);
        op_row_t   r;
        word_t     a, b, res;
        dmem_idx_t idx;
        logic      squash;
        r         = '0;
        squash    = kind >= k_wp;
        r.pc      = next_pc;
        r.op      = op;
        r.rd      = rd;
        r.rs1     = rs1;
        r.rs2     = rs2;
        r.imm     = imm;
        r.use_imm = kind != k_rr && kind != k_br;
        r.use_pc  = kind == k_jal;
        r.wen     = kind != k_st && kind != k_br;
        r.load    = kind == k_ld;
        r.store   = kind == k_st;
        r.jump    = kind == k_jal;
        r.branch  = kind == k_br;
        r.ack     = kind == k_wp_ack;
        r.stall   = stall_next;
        stall_next = 1'b0;
        a   = r.use_pc ? r.pc : model_regs[rs1];
        b   = r.use_imm ? imm : model_regs[rs2];
        idx = dmem_idx_t'((model_regs[rs1] + imm) >> 2);   // word index from address bits 7:2
        res = r.jump ? r.pc + 32'd4 : r.load ? model_mem[idx] : ref_alu(op, a, b);
        r.redirect  = !squash && (r.jump || (r.branch && ref_cond(op, a, b)));
        r.target    = r.jump ? ((a + b) & ~32'd1) : r.pc + imm;
        r.expect_wb = !squash && r.wen;
        r.wb_data   = res;
        if (!squash && r.store) begin
            model_mem[idx] = model_regs[rs2];
        end
        if (!squash && r.wen && rd != 0) begin
            model_regs[rd] = res;
        end
        next_pc = r.redirect ? r.target : r.pc + 32'd4;
        rows.push_back(r);
    endtask

    task automatic build_program();
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        next_pc = 32'h0000_1000;
        add_row(k_ri, alu_pass_b, 1, 0, 0, 32'h1234_5000);   // lui
        add_row(k_ri, alu_add, 1, 1, 0, 32'h678);
        add_row(k_ri, alu_add, 2, 0, 0, 32'hffff_fff0);
        add_row(k_rr, alu_add, 3, 1, 2, '0);
        add_row(k_rr, alu_sub, 4, 1, 2, '0);
        add_row(k_rr, alu_and, 5, 1, 2, '0);
        add_row(k_rr, alu_or, 5, 5, 1, '0);
        add_row(k_rr, alu_xor, 6, 1, 2, '0);
        add_row(k_ri, alu_sll, 6, 1, 0, 32'd4);
        add_row(k_ri, alu_srl, 7, 2, 0, 32'd4);
        add_row(k_ri, alu_sra, 7, 2, 0, 32'd4);
        add_row(k_rr, alu_slt, 9, 2, 1, '0);
        add_row(k_rr, alu_sltu, 9, 2, 1, '0);
        for (int i = 1; i <= 5; i++) begin
            add_row(k_ri, alu_add, 8, 8, 0, i);   // chain deeper than the bypass buffer
        end
        add_row(k_rr, alu_add, 9, 8, 8, '0);
        add_row(k_st, alu_add, 0, 0, 1, 32'h10);
        add_row(k_st, alu_add, 0, 0, 3, 32'h14);
        add_row(k_ld, alu_add, 10, 0, 0, 32'h10);
        stall_next = 1'b1;
        add_row(k_rr, alu_add, 11, 10, 10, '0);
        add_row(k_ld, alu_add, 12, 0, 0, 32'h14);
        stall_next = 1'b1;
        add_row(k_st, alu_add, 0, 0, 12, 32'h18);   // store data comes from the load
        add_row(k_ld, alu_add, 13, 0, 0, 32'h18);
        add_row(k_ri, alu_add, 0, 1, 0, 32'h55);
        add_row(k_rr, alu_add, 14, 0, 1, '0);
        add_row(k_br, alu_beq, 0, 1, 2, 32'h40);
        add_row(k_br, alu_bne, 0, 1, 2, 32'h40);
        add_row(k_wp, alu_add, 5, 5, 0, 32'd1);
        add_row(k_wp_ack, alu_add, 5, 5, 0, 32'd2);
        add_row(k_rr, alu_add, 15, 1, 1, '0);
        add_row(k_jal, alu_add, 16, 0, 0, 32'h101);
        add_row(k_wp_ack, alu_add, 5, 5, 0, 32'd3);
        add_row(k_rr, alu_add, 17, 16, 0, '0);
        rnd = 32'd73;
        for (int i = 0; i < 40; i++) begin
            rnd = xorshift(rnd);
            add_row(k_rr, alu_op_t'(rnd[3:0] % 4'd10), reg_idx_t'(5'd1 + rnd[7:4] % 4'd15),
                    reg_idx_t'(rnd[11:8]), reg_idx_t'(rnd[15:12]), '0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_row(op_row_t r);
        int waits;
        issue_valid   <= 1'b1;
        issue_pc      <= r.pc;
        issue_op      <= r.op;
        issue_rd      <= r.rd;
        issue_rs1     <= r.rs1;
        issue_rs2     <= r.rs2;
        issue_imm     <= r.imm;
        issue_use_imm <= r.use_imm;
        issue_use_pc  <= r.use_pc;
        issue_wen     <= r.wen;
        issue_load    <= r.load;
        issue_store   <= r.store;
        issue_jump    <= r.jump;
        issue_branch  <= r.branch;
        redirect_ack  <= r.ack;
        waits = 0;
        @(negedge clk);
        while (!issue_ready && waits < max_wait) begin
            waits++;
            @(negedge clk);
        end
        assert (issue_ready) else begin
            $display("timeout waiting for issue_ready on the op at pc %h", r.pc);
            timeout_errs++;
            aborted = 1'b1;
        end
        if (!aborted) begin
            assert (waits > 0 || !r.stall) else begin
                $display("no load-use stall before the op at pc %h", r.pc);
                other_errs++;
            end
            @(posedge clk);   // accepted on this edge
            if (r.expect_wb) begin
                exp_rd_q.push_back(r.rd);
                exp_data_q.push_back(r.wb_data);
            end
            if (r.redirect) begin
                exp_redirect = 1'b1;
                exp_target   = r.target;
            end
            if (r.ack) begin
                exp_redirect = 1'b0;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard and redirect monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (!rst && wb_valid && wb_wen) begin
            assert (exp_rd_q.size() > 0) else begin
                $display("writeback to x%0d with data %h that no op should make", wb_rd, wb_data);
                other_errs++;
            end
            if (exp_rd_q.size() > 0) begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (wb_rd == exp_rd) else begin
                    $display("Mismatch wb_rd: got %h expected %h", wb_rd, exp_rd);
                    mismatch_errs++;
                end
                assert (wb_data == exp_data) else begin
                    $display("Mismatch wb_data: got %h expected %h", wb_data, exp_data);
                    mismatch_errs++;
                end
            end
        end
        if (!rst) begin
            assert (redirect_valid == exp_redirect) else begin
                $display("Mismatch redirect_valid: got %h expected %h", redirect_valid,
                         exp_redirect);
                mismatch_errs++;
            end
            assert (!(redirect_valid && exp_redirect) || redirect_pc == exp_target) else begin
                $display("Mismatch redirect_pc: got %h expected %h", redirect_pc, exp_target);
                mismatch_errs++;
            end
        end
    end

    initial begin
        int waits;
        issue_valid   = 1'b0;
        issue_pc      = '0;
        issue_op      = alu_add;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_imm     = '0;
        issue_use_imm = 1'b0;
        issue_use_pc  = 1'b0;
        issue_wen     = 1'b0;
        issue_load    = 1'b0;
        issue_store   = 1'b0;
        issue_jump    = 1'b0;
        issue_branch  = 1'b0;
        redirect_ack  = 1'b0;
        exp_redirect  = 1'b0;
        stall_next    = 1'b0;
        aborted       = 1'b0;
        mismatch_errs = 0;
        timeout_errs  = 0;
        other_errs    = 0;
        build_program();
        waits = 0;
        @(posedge clk);
        while (rst && waits < max_wait) begin
            waits++;
            @(posedge clk);
        end
        assert (!rst) else begin
            $display("timeout waiting for reset to end");
            timeout_errs++;
            aborted = 1'b1;
        end
        foreach (rows[i]) begin
            if (!aborted) begin
                drive_row(rows[i]);
            end
        end
        issue_valid  <= 1'b0;
        redirect_ack <= 1'b0;
        waits = 0;
        while (exp_rd_q.size() != 0 && waits < max_wait) begin
            waits++;
            @(negedge clk);
        end
        assert (exp_rd_q.size() == 0) else begin
            $display("timeout with %0d writebacks still outstanding", exp_rd_q.size());
            timeout_errs++;
        end
        repeat (3) @(negedge clk);   // catch stray writebacks
        total = mismatch_errs + timeout_errs + other_errs
              + exec_top_inst.exu_inst.asserts_inst.fail_count;
        $display("errors: %0d mismatch, %0d timeout, %0d other, %0d assertion", mismatch_errs,
                 timeout_errs, other_errs, exec_top_inst.exu_inst.asserts_inst.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
